// ==== src/rv32i_exec_pkg.sv ====
package rv32i_exec_pkg;

    localparam int XLEN       = 32;
    localparam int SHAMT_W    = 5;    // rv32i shift range
    localparam int INSN_BYTES = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;
    typedef logic [3:0]      strb_t;

    // major opcodes with all-zero as the pipeline bubble
    typedef enum logic [6:0] {
        OP_NONE   = 7'b0000000,
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // alu
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;  // srl / sra
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // load/store widths
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // sub, sra, srai

    localparam strb_t STRB_BYTE = 4'b0001;
    localparam strb_t STRB_HALF = 4'b0011;
    localparam strb_t STRB_WORD = 4'b1111;

endpackage

// ==== src/exec_op_if.sv ====
`timescale 1ns/1ps

interface exec_op_if (
    input logic CLK
);

    rv32i_exec_pkg::word_t     pc;
    rv32i_exec_pkg::opcode_e   opcode;
    rv32i_exec_pkg::reg_addr_t rd_addr;
    rv32i_exec_pkg::word_t     rs1_data;
    rv32i_exec_pkg::word_t     rs2_data;
    rv32i_exec_pkg::funct3_t   funct3;
    rv32i_exec_pkg::funct7_t   funct7;
    rv32i_exec_pkg::word_t     imm;    // already extended by decode

    modport src (
        output pc, opcode, rd_addr, rs1_data, rs2_data, funct3, funct7, imm
    );

    // clock only feeds the units' checkers
    modport sink (
        input CLK,
        input pc, opcode, rd_addr, rs1_data, rs2_data, funct3, funct7, imm
    );

endinterface

// ==== src/exec_input_reg.sv ====
`timescale 1ns/1ps

module exec_input_reg (
    input  logic                      CLK,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      stall,
    input  logic                      mem_wait,
    input  rv32i_exec_pkg::word_t     pc,
    input  rv32i_exec_pkg::opcode_e   opcode,
    input  rv32i_exec_pkg::reg_addr_t rd_addr,
    input  rv32i_exec_pkg::word_t     rs1_data,
    input  rv32i_exec_pkg::word_t     rs2_data,
    input  rv32i_exec_pkg::word_t     imm,
    input  rv32i_exec_pkg::funct3_t   funct3,
    input  rv32i_exec_pkg::funct7_t   funct7,
    exec_op_if.src                    op
);

    logic load_bubble;

    // rst/flush beat mem_wait, mem_wait beats stall
    assign load_bubble = rst || flush || (stall && !mem_wait);

    always_ff @(posedge CLK) begin
        if (load_bubble) begin
            op.pc       <= '0;
            op.opcode   <= rv32i_exec_pkg::OP_NONE;
            op.rd_addr  <= '0;
            op.rs1_data <= '0;
            op.rs2_data <= '0;
            op.funct3   <= '0;
            op.funct7   <= '0;
            op.imm      <= '0;
        end else if (!mem_wait) begin
            op.pc       <= pc;
            op.opcode   <= opcode;
            op.rd_addr  <= rd_addr;
            op.rs1_data <= rs1_data;
            op.rs2_data <= rs2_data;
            op.funct3   <= funct3;
            op.funct7   <= funct7;
            op.imm      <= imm;
        end
        // mem_wait alone holds the register
    end

    flush_gives_bubble: assert property (
        @(posedge CLK) flush |=> op.opcode == rv32i_exec_pkg::OP_NONE
    );

endmodule

// ==== src/exec_alu.sv ====
`timescale 1ns/1ps

module exec_alu (
    exec_op_if.sink                   op,
    output logic                      reg_w_en,
    output rv32i_exec_pkg::reg_addr_t reg_w_rd,
    output rv32i_exec_pkg::word_t     reg_w_data
);

    logic                               is_reg;
    logic                               f7_base;
    logic                               f7_alt;
    logic                               valid;
    logic [rv32i_exec_pkg::SHAMT_W-1:0] shamt;
    rv32i_exec_pkg::word_t              opb;
    rv32i_exec_pkg::word_t              alu_res;
    rv32i_exec_pkg::word_t              result;

    assign is_reg  = (op.opcode == rv32i_exec_pkg::OP_REG);
    assign f7_base = (op.funct7 == rv32i_exec_pkg::F7_BASE);
    assign f7_alt  = (op.funct7 == rv32i_exec_pkg::F7_ALT);
    assign opb     = is_reg ? op.rs2_data : op.imm;
    assign shamt   = opb[rv32i_exec_pkg::SHAMT_W-1:0];

    // which opcode/funct combinations write rd
    always_comb begin
        case (op.opcode)
            rv32i_exec_pkg::OP_REG:
                valid = f7_base || (f7_alt && (op.funct3 == rv32i_exec_pkg::F3_ADD_SUB
                                            || op.funct3 == rv32i_exec_pkg::F3_SR));
            rv32i_exec_pkg::OP_IMM: begin
                case (op.funct3)
                    rv32i_exec_pkg::F3_SLL: valid = f7_base;
                    rv32i_exec_pkg::F3_SR:  valid = f7_base || f7_alt;
                    default:                valid = 1'b1;
                endcase
            end
            rv32i_exec_pkg::OP_LUI,
            rv32i_exec_pkg::OP_AUIPC,
            rv32i_exec_pkg::OP_JAL:  valid = 1'b1;
            rv32i_exec_pkg::OP_JALR: valid = (op.funct3 == '0);
            default:                 valid = 1'b0;
        endcase
    end

    always_comb begin
        case (op.funct3)
            rv32i_exec_pkg::F3_ADD_SUB:
                alu_res = (is_reg && f7_alt) ? op.rs1_data - opb : op.rs1_data + opb;
            rv32i_exec_pkg::F3_SLL:
                alu_res = op.rs1_data << shamt;
            rv32i_exec_pkg::F3_SLT:
                alu_res = {{(rv32i_exec_pkg::XLEN-1){1'b0}},
                           $signed(op.rs1_data) < $signed(opb)};
            rv32i_exec_pkg::F3_SLTU:
                alu_res = {{(rv32i_exec_pkg::XLEN-1){1'b0}}, op.rs1_data < opb};
            rv32i_exec_pkg::F3_XOR:
                alu_res = op.rs1_data ^ opb;
            rv32i_exec_pkg::F3_SR:
                alu_res = f7_alt ? rv32i_exec_pkg::word_t'($signed(op.rs1_data) >>> shamt)
                                 : op.rs1_data >> shamt;
            rv32i_exec_pkg::F3_OR:
                alu_res = op.rs1_data | opb;
            default:
                alu_res = op.rs1_data & opb;
        endcase
    end

    always_comb begin
        case (op.opcode)
            rv32i_exec_pkg::OP_LUI:   result = op.imm;
            rv32i_exec_pkg::OP_AUIPC: result = op.pc + op.imm;
            rv32i_exec_pkg::OP_JAL,
            rv32i_exec_pkg::OP_JALR:  // link address
                result = op.pc + rv32i_exec_pkg::word_t'(rv32i_exec_pkg::INSN_BYTES);
            default:                  result = alu_res;
        endcase
    end

    assign reg_w_en   = valid;
    assign reg_w_rd   = valid ? op.rd_addr : '0;
    assign reg_w_data = valid ? result : '0;

    no_wb_for_mem_or_branch: assert property (
        @(posedge op.CLK) reg_w_en |-> !(op.opcode inside {rv32i_exec_pkg::OP_LOAD,
                                                         rv32i_exec_pkg::OP_STORE,
                                                         rv32i_exec_pkg::OP_BRANCH})
    );

endmodule

// ==== src/exec_branch.sv ====
`timescale 1ns/1ps

module exec_branch (
    exec_op_if.sink               op,
    output logic                  jmp_do,
    output rv32i_exec_pkg::word_t jmp_pc
);

    logic                  take;
    rv32i_exec_pkg::word_t target;
    rv32i_exec_pkg::word_t jalr_sum;

    assign jalr_sum = op.rs1_data + op.imm;

    always_comb begin
        take   = 1'b0;
        target = op.pc + op.imm;
        case (op.opcode)
            rv32i_exec_pkg::OP_BRANCH: begin
                case (op.funct3)
                    rv32i_exec_pkg::F3_BEQ:  take = op.rs1_data == op.rs2_data;
                    rv32i_exec_pkg::F3_BNE:  take = op.rs1_data != op.rs2_data;
                    rv32i_exec_pkg::F3_BLT:  take = $signed(op.rs1_data) < $signed(op.rs2_data);
                    rv32i_exec_pkg::F3_BGE:  take = $signed(op.rs1_data) >= $signed(op.rs2_data);
                    rv32i_exec_pkg::F3_BLTU: take = op.rs1_data < op.rs2_data;
                    rv32i_exec_pkg::F3_BGEU: take = op.rs1_data >= op.rs2_data;
                    default:                 take = 1'b0;   // 010, 011 undefined
                endcase
            end
            rv32i_exec_pkg::OP_JAL: begin
                take = 1'b1;
            end
            rv32i_exec_pkg::OP_JALR: begin
                take   = (op.funct3 == '0);
                target = {jalr_sum[rv32i_exec_pkg::XLEN-1:1], 1'b0};
            end
            default: begin
                take = 1'b0;
            end
        endcase
    end

    assign jmp_do = take;
    assign jmp_pc = take ? target : '0;

    // relies on decode keeping bit 0 of b/j immediates clear
    jump_target_aligned: assert property (
        @(posedge op.CLK) jmp_do |-> !jmp_pc[0]
    );

endmodule

// ==== src/exec_lsu.sv ====
`timescale 1ns/1ps

module exec_lsu (
    exec_op_if.sink                   op,
    output logic                      mem_r_en,
    output rv32i_exec_pkg::reg_addr_t mem_r_rd,
    output rv32i_exec_pkg::word_t     mem_r_addr,
    output rv32i_exec_pkg::strb_t     mem_r_strb,
    output logic                      mem_r_signed,
    output logic                      mem_w_en,
    output rv32i_exec_pkg::word_t     mem_w_addr,
    output rv32i_exec_pkg::strb_t     mem_w_strb,
    output rv32i_exec_pkg::word_t     mem_w_data
);

    rv32i_exec_pkg::word_t addr;

    assign addr = op.rs1_data + op.imm;  // shared by loads and stores

    always_comb begin
        mem_r_en     = 1'b0;
        mem_r_rd     = '0;
        mem_r_addr   = '0;
        mem_r_strb   = '0;
        mem_r_signed = 1'b0;
        mem_w_en     = 1'b0;
        mem_w_addr   = '0;
        mem_w_strb   = '0;
        mem_w_data   = '0;
        case (op.opcode)
            rv32i_exec_pkg::OP_LOAD: begin
                mem_r_en = 1'b1;
                case (op.funct3)
                    rv32i_exec_pkg::F3_B: begin
                        mem_r_strb   = rv32i_exec_pkg::STRB_BYTE;
                        mem_r_signed = 1'b1;
                    end
                    rv32i_exec_pkg::F3_H: begin
                        mem_r_strb   = rv32i_exec_pkg::STRB_HALF;
                        mem_r_signed = 1'b1;
                    end
                    rv32i_exec_pkg::F3_W:  mem_r_strb = rv32i_exec_pkg::STRB_WORD;
                    rv32i_exec_pkg::F3_BU: mem_r_strb = rv32i_exec_pkg::STRB_BYTE;
                    rv32i_exec_pkg::F3_HU: mem_r_strb = rv32i_exec_pkg::STRB_HALF;
                    default:               mem_r_en   = 1'b0;
                endcase
                if (mem_r_en) begin
                    mem_r_rd   = op.rd_addr;  // destination rides with the request
                    mem_r_addr = addr;
                end
            end
            rv32i_exec_pkg::OP_STORE: begin
                mem_w_en = 1'b1;
                case (op.funct3)
                    rv32i_exec_pkg::F3_B: mem_w_strb = rv32i_exec_pkg::STRB_BYTE;
                    rv32i_exec_pkg::F3_H: mem_w_strb = rv32i_exec_pkg::STRB_HALF;
                    rv32i_exec_pkg::F3_W: mem_w_strb = rv32i_exec_pkg::STRB_WORD;
                    default:              mem_w_en   = 1'b0;
                endcase
                if (mem_w_en) begin
                    mem_w_addr = addr;
                    mem_w_data = op.rs2_data;
                end
            end
            default: begin
            end
        endcase
    end

    one_access_only: assert property (
        @(posedge op.CLK) !(mem_r_en && mem_w_en)
    );

endmodule

// ==== src/rv32i_exec.sv ====
`timescale 1ns/1ps

module rv32i_exec (
    input  logic                      CLK,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      stall,
    input  logic                      mem_wait,

    // from decode
    input  rv32i_exec_pkg::word_t     pc,
    input  rv32i_exec_pkg::opcode_e   opcode,
    input  rv32i_exec_pkg::reg_addr_t rd_addr,
    input  rv32i_exec_pkg::word_t     rs1_data,
    input  rv32i_exec_pkg::word_t     rs2_data,
    input  rv32i_exec_pkg::funct3_t   funct3,
    input  rv32i_exec_pkg::funct7_t   funct7,
    input  rv32i_exec_pkg::word_t     imm,

    // register write-back
    output logic                      reg_w_en,
    output rv32i_exec_pkg::reg_addr_t reg_w_rd,
    output rv32i_exec_pkg::word_t     reg_w_data,

    // memory read
    output logic                      mem_r_en,
    output rv32i_exec_pkg::reg_addr_t mem_r_rd,
    output rv32i_exec_pkg::word_t     mem_r_addr,
    output rv32i_exec_pkg::strb_t     mem_r_strb,
    output logic                      mem_r_signed,

    // memory write
    output logic                      mem_w_en,
    output rv32i_exec_pkg::word_t     mem_w_addr,
    output rv32i_exec_pkg::strb_t     mem_w_strb,
    output rv32i_exec_pkg::word_t     mem_w_data,

    // pc redirect
    output logic                      jmp_do,
    output rv32i_exec_pkg::word_t     jmp_pc
);

    exec_op_if exec_op_if_i (.CLK(CLK));

    exec_input_reg exec_input_reg_i (
        .CLK      (CLK),
        .rst      (rst),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .pc       (pc),
        .opcode   (opcode),
        .rd_addr  (rd_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .funct3   (funct3),
        .funct7   (funct7),
        .op       (exec_op_if_i.src)
    );

    exec_alu exec_alu_i (
        .op         (exec_op_if_i.sink),
        .reg_w_en   (reg_w_en),
        .reg_w_rd   (reg_w_rd),
        .reg_w_data (reg_w_data)
    );

    exec_branch exec_branch_i (
        .op     (exec_op_if_i.sink),
        .jmp_do (jmp_do),
        .jmp_pc (jmp_pc)
    );

    exec_lsu exec_lsu_i (
        .op           (exec_op_if_i.sink),
        .mem_r_en     (mem_r_en),
        .mem_r_rd     (mem_r_rd),
        .mem_r_addr   (mem_r_addr),
        .mem_r_strb   (mem_r_strb),
        .mem_r_signed (mem_r_signed),
        .mem_w_en     (mem_w_en),
        .mem_w_addr   (mem_w_addr),
        .mem_w_strb   (mem_w_strb),
        .mem_w_data   (mem_w_data)
    );

endmodule

// ==== tests/rv32i_exec_model.svh ====
`ifndef RV32I_EXEC_MODEL_SVH
`define RV32I_EXEC_MODEL_SVH

typedef struct packed {
    rv32i_exec_pkg::word_t     pc, rs1_data, rs2_data, imm;
    rv32i_exec_pkg::opcode_e   opcode;
    rv32i_exec_pkg::reg_addr_t rd_addr;
    rv32i_exec_pkg::funct3_t   funct3;
    rv32i_exec_pkg::funct7_t   funct7;
} insn_t;

typedef struct packed {
    logic                      reg_w_en, mem_r_en, mem_r_signed, mem_w_en, jmp_do;
    rv32i_exec_pkg::reg_addr_t reg_w_rd, mem_r_rd;
    rv32i_exec_pkg::strb_t     mem_r_strb, mem_w_strb;
    rv32i_exec_pkg::word_t     reg_w_data, mem_r_addr, mem_w_addr, mem_w_data, jmp_pc;
} out_t;

// stage outputs while insn sits in the execute register
function automatic out_t expected_outputs(input insn_t i);
    out_t                  o;
    rv32i_exec_pkg::word_t b, res, addr, sign_fill;
    logic [4:0]            sh;
    logic                  is_reg, alt, legal, take, is_jalr, is_load, is_store;
    o         = '0;
    is_reg    = (i.opcode == rv32i_exec_pkg::OP_REG);
    alt       = (i.funct7 == rv32i_exec_pkg::F7_ALT);
    b         = is_reg ? i.rs2_data : i.imm;
    sh        = b[4:0];
    addr      = i.rs1_data + i.imm;
    sign_fill = (alt && i.rs1_data[31]) ? ~(32'hffff_ffff >> sh) : 32'd0;
    case (i.funct3)
        3'b000:  res = (is_reg && alt) ? i.rs1_data - b : i.rs1_data + b;
        3'b001:  res = i.rs1_data << sh;
        3'b010:  res = {31'd0, $signed(i.rs1_data) < $signed(b)};
        3'b011:  res = {31'd0, i.rs1_data < b};
        3'b100:  res = i.rs1_data ^ b;
        3'b101:  res = (i.rs1_data >> sh) | sign_fill;  // srl, sra
        3'b110:  res = i.rs1_data | b;
        default: res = i.rs1_data & b;
    endcase
    case (i.funct3)
        3'b000:  take = i.rs1_data == i.rs2_data;
        3'b001:  take = i.rs1_data != i.rs2_data;
        3'b100:  take = $signed(i.rs1_data) < $signed(i.rs2_data);
        3'b101:  take = $signed(i.rs1_data) >= $signed(i.rs2_data);
        3'b110:  take = i.rs1_data < i.rs2_data;
        3'b111:  take = i.rs1_data >= i.rs2_data;
        default: take = 1'b0;
    endcase
    // legal funct7 values differ between register and immediate forms
    if (is_reg) begin
        legal = i.funct7 == 7'd0 || (alt && i.funct3 inside {3'b000, 3'b101});
    end else begin
        legal = (i.funct3 == 3'b001) ? i.funct7 == 7'd0
                                     : (i.funct3 != 3'b101 || i.funct7 == 7'd0 || alt);
    end
    is_jalr  = i.opcode == rv32i_exec_pkg::OP_JALR && i.funct3 == 3'b000;
    is_load  = i.opcode == rv32i_exec_pkg::OP_LOAD
               && i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    is_store = i.opcode == rv32i_exec_pkg::OP_STORE && i.funct3 inside {3'b000, 3'b001, 3'b010};
    o.reg_w_en = is_jalr
                 || (legal && i.opcode inside {rv32i_exec_pkg::OP_REG, rv32i_exec_pkg::OP_IMM})
                 || i.opcode inside {rv32i_exec_pkg::OP_LUI, rv32i_exec_pkg::OP_AUIPC,
                                     rv32i_exec_pkg::OP_JAL};
    o.jmp_do   = is_jalr || i.opcode == rv32i_exec_pkg::OP_JAL
                 || (take && i.opcode == rv32i_exec_pkg::OP_BRANCH);
    if (o.reg_w_en) begin
        o.reg_w_rd   = i.rd_addr;
        o.reg_w_data = (i.opcode == rv32i_exec_pkg::OP_LUI)   ? i.imm
                     : (i.opcode == rv32i_exec_pkg::OP_AUIPC) ? i.pc + i.imm
                     : (i.opcode inside {rv32i_exec_pkg::OP_REG, rv32i_exec_pkg::OP_IMM}) ? res
                     : i.pc + 32'd4;  // link
    end
    if (o.jmp_do) begin
        o.jmp_pc = is_jalr ? (addr & 32'hffff_fffe) : i.pc + i.imm;
    end
    if (is_load) begin
        o.mem_r_en     = 1'b1;
        o.mem_r_rd     = i.rd_addr;
        o.mem_r_addr   = addr;
        o.mem_r_strb   = (i.funct3[1:0] == 2'b00) ? 4'b0001
                       : (i.funct3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
        o.mem_r_signed = i.funct3 inside {3'b000, 3'b001};  // lb, lh
    end
    if (is_store) begin
        o.mem_w_en   = 1'b1;
        o.mem_w_addr = addr;
        o.mem_w_strb = (i.funct3 == 3'b000) ? 4'b0001 : (i.funct3 == 3'b001) ? 4'b0011 : 4'b1111;
        o.mem_w_data = i.rs2_data;
    end
    return o;
endfunction

`endif

// ==== tests/rv32i_exec_tb.sv ====
`timescale 1ns/1ps

module rv32i_exec_tb;

    `include "rv32i_exec_model.svh"

    localparam int N_INSNS    = 4000;
    localparam int WAIT_LIMIT = 20;
    localparam int RUN_LIMIT  = N_INSNS + 100;

    localparam rv32i_exec_pkg::opcode_e KEPT_OPS [9] = '{
        rv32i_exec_pkg::OP_REG, rv32i_exec_pkg::OP_IMM, rv32i_exec_pkg::OP_LUI,
        rv32i_exec_pkg::OP_AUIPC, rv32i_exec_pkg::OP_JAL, rv32i_exec_pkg::OP_JALR,
        rv32i_exec_pkg::OP_BRANCH, rv32i_exec_pkg::OP_LOAD, rv32i_exec_pkg::OP_STORE
    };

    logic      CLK;
    logic      rst, flush, stall, mem_wait;
    insn_t     drv;
    insn_t     held;  // model copy of the execute register
    wire out_t act;
    logic      ref_live  = 1'b0;
    logic      stim_done = 1'b0;
    int        errors    = 0;
    int        checks    = 0;

    rv32i_exec rv32i_exec_i (
        .CLK (CLK), .rst (rst), .flush (flush), .stall (stall), .mem_wait (mem_wait),
        .pc (drv.pc), .opcode (drv.opcode), .rd_addr (drv.rd_addr), .rs1_data (drv.rs1_data),
        .rs2_data (drv.rs2_data), .funct3 (drv.funct3), .funct7 (drv.funct7), .imm (drv.imm),
        .reg_w_en (act.reg_w_en), .reg_w_rd (act.reg_w_rd), .reg_w_data (act.reg_w_data),
        .mem_r_en (act.mem_r_en), .mem_r_rd (act.mem_r_rd), .mem_r_addr (act.mem_r_addr),
        .mem_r_strb (act.mem_r_strb), .mem_r_signed (act.mem_r_signed),
        .mem_w_en (act.mem_w_en), .mem_w_addr (act.mem_w_addr), .mem_w_strb (act.mem_w_strb),
        .mem_w_data (act.mem_w_data), .jmp_do (act.jmp_do), .jmp_pc (act.jmp_pc)
    );

    initial begin : clock_gen
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // rst/flush, then mem_wait holds, then stall clears
    task automatic latch_model;
        if (rst || flush) begin
            held = '0;
        end else if (!mem_wait) begin
            held = stall ? insn_t'('0) : drv;
        end
        ref_live = 1'b1;
    endtask

    task automatic drive_random;
        drv.pc     = $urandom() & 32'hffff_fffc;
        drv.opcode = KEPT_OPS[$urandom_range(8)];
        if ($urandom_range(15) == 0) begin
            drv.opcode = rv32i_exec_pkg::opcode_e'(7'($urandom()));  // mostly unknown codes
        end
        drv.rd_addr  = 5'($urandom());
        drv.rs1_data = $urandom();
        drv.rs2_data = ($urandom_range(3) == 0) ? drv.rs1_data : $urandom();
        drv.funct3   = 3'($urandom());
        drv.funct7   = ($urandom_range(1) == 0) ? rv32i_exec_pkg::F7_BASE : rv32i_exec_pkg::F7_ALT;
        if ($urandom_range(15) == 0) begin
            drv.funct7 = 7'($urandom());
        end
        drv.imm = $urandom();
        if (drv.opcode inside {rv32i_exec_pkg::OP_BRANCH, rv32i_exec_pkg::OP_JAL}) begin
            drv.imm[0] = 1'b0;  // b/j offsets are even
        end
        flush    = ($urandom_range(19) == 0);
        stall    = ($urandom_range(11) == 0);
        mem_wait = mem_wait ? ($urandom_range(1) == 0) : ($urandom_range(7) == 0);
    endtask

    task automatic compare_outputs;
        out_t e;
        e = expected_outputs(held);
        check_value("reg_w_en", act.reg_w_en, e.reg_w_en);
        check_value("reg_w_rd", act.reg_w_rd, e.reg_w_rd);
        check_value("reg_w_data", act.reg_w_data, e.reg_w_data);
        check_value("mem_r_en", act.mem_r_en, e.mem_r_en);
        check_value("mem_r_rd", act.mem_r_rd, e.mem_r_rd);
        check_value("mem_r_addr", act.mem_r_addr, e.mem_r_addr);
        check_value("mem_r_strb", act.mem_r_strb, e.mem_r_strb);
        check_value("mem_r_signed", act.mem_r_signed, e.mem_r_signed);
        check_value("mem_w_en", act.mem_w_en, e.mem_w_en);
        check_value("mem_w_addr", act.mem_w_addr, e.mem_w_addr);
        check_value("mem_w_strb", act.mem_w_strb, e.mem_w_strb);
        check_value("mem_w_data", act.mem_w_data, e.mem_w_data);
        check_value("jmp_do", act.jmp_do, e.jmp_do);
        check_value("jmp_pc", act.jmp_pc, e.jmp_pc);
        check_value("mem_r_en and mem_w_en", act.mem_r_en & act.mem_w_en, 1'b0);
    endtask

    task automatic end_run(input bit timed_out);
        $display("run finished: %0d checks, %0d errors, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    initial begin : stimulus
        void'($urandom(32'hfc3a));
        rst      = 1'b1;
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        drv      = '0;
        held     = '0;
        repeat (3) begin
            @(posedge CLK);
            latch_model();
        end
        #2;
        rst = 1'b0;
        @(negedge CLK);
        check_value("enables after reset", {act.reg_w_en, act.mem_r_en, act.mem_w_en, act.jmp_do}, 0);
        for (int n = 0; n < N_INSNS; n++) begin
            @(posedge CLK);
            latch_model();
            #2;
            drive_random();
        end
        repeat (2) begin  // drain with bubbles
            @(posedge CLK);
            latch_model();
            #2;
            drv      = '0;
            flush    = 1'b0;
            stall    = 1'b0;
            mem_wait = 1'b0;
        end
        stim_done = 1'b1;
    end

    initial begin : compare_process
        int cycles;
        cycles = 0;
        while (!ref_live && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        cycles = 0;
        while (ref_live && !stim_done && cycles < RUN_LIMIT) begin
            compare_outputs();
            @(negedge CLK);
            cycles++;
        end
        if (!ref_live || !stim_done) begin
            $display("timeout: the stimulus never reached its end");
            end_run(1'b1);
        end else begin
            end_run(1'b0);
        end
    end

endmodule

// ==== rv32i_exec.f ====
+incdir+tests
src/rv32i_exec_pkg.sv
src/exec_op_if.sv
src/exec_input_reg.sv
src/exec_alu.sv
src/exec_branch.sv
src/exec_lsu.sv
src/rv32i_exec.sv
tests/rv32i_exec_tb.sv
